//--- build.f
uniboard_pkg.sv
uniboard_if.sv
baud_timer.sv
uart_rx.sv
uart_tx.sv
frame_decoder.sv
protocol_sequencer.sv
peripheral_bank.sv
uniboard_top.sv
tb_uniboard.sv

//--- Makefile
VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS ?= --binary --timing -Wno-fatal
TOP ?= tb_uniboard
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
PASS_TEXT = All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb_uniboard.sv
// tb_uniboard: uart driver and monitor, reply reference model, checker, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_uniboard;
	import uniboard_pkg::*;

	typedef logic [7:0] byte_q_t [$];

	localparam int SEED = 32'h94f7_3cc0;
	localparam longint CLK_PERIOD_NS = 10;
	localparam int BYTE_CYCLES = 10 * BAUD_DIV;
	// surplus reply bytes would show up well inside this window
	localparam int QUIET_CYCLES = 3 * BYTE_CYCLES;
	// 39 commands plus the idle check after reset
	localparam int NUM_FRAMES = 40;
	// escaped command 14, escaped reply 14, stray bytes and quiet window
	localparam int WORST_BYTES = 40;
	localparam longint WATCHDOG_NS =
		2 * NUM_FRAMES * WORST_BYTES * BYTE_CYCLES * CLK_PERIOD_NS;

	logic clk_12MHz;
	logic reset;
	logic uart_rx;
	logic uart_tx;

	// bytes seen on uart_tx, bytes the model predicts
	byte_q_t got_q;
	byte_q_t exp_q;
	logic [31:0] model_scratch [4];
	int error_count = 0;
	int reply_index = 0;

	uniboard_top dut0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx)
	);

	initial
	begin
		clk_12MHz = 1'b0;
		forever #5 clk_12MHz = ~clk_12MHz;
	end

	task automatic fail_run();
		error_count++;
		$display("Test failures found");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected)
		begin
			$display("ERROR at %0t ns: %s mismatch, got %0h expected %0h",
				$time, what, got, expected);
			fail_run();
		end
	endtask

	function automatic bit is_framing(input logic [7:0] b);
		return (b == BYTE_START) || (b == BYTE_END) || (b == BYTE_ESC);
	endfunction

	// start, escaped payload, end
	function automatic byte_q_t escaped_frame(input byte_q_t payload);
		byte_q_t s;
		s.push_back(BYTE_START);
		foreach (payload[i])
		begin
			if (is_framing(payload[i]))
				s.push_back(BYTE_ESC);
			s.push_back(payload[i]);
		end
		s.push_back(BYTE_END);
		return s;
	endfunction

	function automatic byte_q_t make_payload(input logic [7:0] header, input logic [7:0] addr,
		input int ndata, input logic [31:0] word);
		byte_q_t p;
		p.push_back(header);
		p.push_back(addr);
		for (int i = 0; i < ndata; i++)
			p.push_back(word[8*i +: 8]);
		return p;
	endfunction

	// reference: expected reply bytes, updates the register model
	function automatic byte_q_t expected_reply(input byte_q_t payload);
		byte_q_t raw;
		byte_q_t reply;
		logic [7:0] field [6];
		logic [31:0] word;
		logic [PERIPH_ID_W-1:0] id;
		int size;
		// short payloads zero filled, extra bytes dropped
		for (int i = 0; i < 6; i++)
			field[i] = (i < payload.size()) ? payload[i] : 8'h00;
		if (payload.size() < 2)
			return reply;
		word = {field[5], field[4], field[3], field[2]};
		id = field[0][PERIPH_ID_W-1:0];
		if (!field[0][READ_FLAG_BIT] && id == PERIPH_SCRATCH)
			model_scratch[field[1][1:0]] = word;
		if (id == PERIPH_SCRATCH)
		begin
			word = model_scratch[field[1][1:0]];
			size = 4;
		end
		else if (id == PERIPH_IDENT)
		begin
			word = {16'h0000, UNIBOARD_ID};
			size = 2;
		end
		else
			size = 0;
		raw.push_back(field[0]);
		raw.push_back(field[1]);
		// data least significant byte first
		for (int i = 0; i < size; i++)
			raw.push_back(word[8*i +: 8]);
		reply.push_back(BYTE_START);
		foreach (raw[i])
		begin
			if (is_framing(raw[i]))
				reply.push_back(BYTE_ESC);
			reply.push_back(raw[i]);
		end
		reply.push_back(BYTE_END);
		return reply;
	endfunction

	// one bit period, driven on the rising edge
	task automatic drive_bit(input logic v);
		uart_rx <= v;
		repeat (BAUD_DIV) @(posedge clk_12MHz);
	endtask

	task automatic send_byte(input logic [7:0] b);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(b[i]);
		drive_bit(1'b1);
	endtask

	task automatic wait_for_reply(input int n);
		int limit;
		int cycles;
		limit = (n + 4) * BYTE_CYCLES;
		cycles = 0;
		while (exp_q.size() > 0 && cycles < limit)
		begin
			@(posedge clk_12MHz);
			cycles++;
		end
		if (exp_q.size() > 0)
		begin
			$display("reply incomplete: %0d bytes still missing at %0t ns",
				exp_q.size(), $time);
			fail_run();
		end
		// line must stay quiet afterwards
		repeat (QUIET_CYCLES) @(posedge clk_12MHz);
	endtask

	task automatic run_command(input byte_q_t stream, input byte_q_t payload);
		byte_q_t reply;
		reply = expected_reply(payload);
		foreach (reply[i])
			exp_q.push_back(reply[i]);
		foreach (stream[i])
			send_byte(stream[i]);
		wait_for_reply(reply.size());
	endtask

	task automatic do_command(input byte_q_t payload);
		run_command(escaped_frame(payload), payload);
	endtask

	// uart_tx decoder, samples at mid bit
	initial
	begin
		logic [7:0] b;
		forever
		begin
			@(posedge clk_12MHz);
			if (!reset && uart_tx === 1'b0)
			begin
				repeat (BAUD_DIV / 2) @(posedge clk_12MHz);
				for (int i = 0; i < 8; i++)
				begin
					repeat (BAUD_DIV) @(posedge clk_12MHz);
					b[i] = uart_tx;
				end
				repeat (BAUD_DIV) @(posedge clk_12MHz);
				if (uart_tx !== 1'b1)
				begin
					$display("stop bit on uart_tx is low at %0t ns", $time);
					fail_run();
				end
				got_q.push_back(b);
			end
		end
	end

	// compares received bytes against the model in order
	always @(posedge clk_12MHz)
	begin
		if (got_q.size() > 0)
		begin
			if (exp_q.size() == 0)
			begin
				$display("byte %0h arrived on uart_tx with no reply pending at %0t ns",
					got_q[0], $time);
				fail_run();
			end
			else
			begin
				compare_value(32'(got_q.pop_front()), 32'(exp_q.pop_front()),
					$sformatf("reply byte %0d", reply_index));
				reply_index++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, simulation hung", WATCHDOG_NS);
		fail_run();
	end

	initial
	begin
		byte_q_t p;
		byte_q_t s;
		logic [7:0] addr;
		logic [31:0] word;
		void'($urandom(SEED));
		reset = 1'b1;
		uart_rx = 1'b1;
		for (int i = 0; i < 4; i++)
			model_scratch[i] = 32'h0;
		repeat (2) @(posedge clk_12MHz);
		reset <= 1'b0;

		$display("idle after reset, scratch reads zero");
		repeat (QUIET_CYCLES)
		begin
			@(posedge clk_12MHz);
			compare_value(32'(uart_tx), 32'd1, "uart_tx idle after reset");
		end
		for (int a = 0; a < 4; a++)
			do_command(make_payload(8'h82, 8'(a), 0, 32'h0));

		$display("random scratch writes with read-back");
		repeat (8)
		begin
			addr = 8'($urandom);
			word = $urandom;
			do_command(make_payload(8'h02, addr, 4, word));
			do_command(make_payload(8'h82, addr, 0, 32'h0));
		end

		$display("identity register and unused ids");
		do_command(make_payload(8'h87, 8'h00, 0, 32'h0));
		do_command(make_payload(8'h07, 8'h00, 4, $urandom));
		do_command(make_payload(8'h87, 8'h00, 0, 32'h0));
		do_command(make_payload(8'h85, 8'h10, 0, 32'h0));
		do_command(make_payload(8'h0A, 8'h20, 4, 32'h1234_5678));

		$display("framing bytes in data, address and header");
		do_command(make_payload(8'h02, 8'h1B, 4, 32'h1B17_0100));
		do_command(make_payload(8'h82, 8'h1B, 0, 32'h0));
		do_command(make_payload(8'h02, 8'h01, 4, 32'h0117_1B01));
		do_command(make_payload(8'h82, 8'h01, 0, 32'h0));
		do_command(make_payload(8'h17, 8'h17, 4, 32'h1B1B_1B1B));
		do_command(make_payload(8'h97, 8'h17, 0, 32'h0));

		$display("malformed input");
		// one byte, then no bytes
		p = make_payload(8'h82, 8'h00, 0, 32'h0);
		void'(p.pop_back());
		do_command(p);
		p.delete();
		do_command(p);
		// noise outside a frame, including a lone end byte
		p = make_payload(8'h82, 8'h00, 0, 32'h0);
		s = escaped_frame(p);
		s.push_front(BYTE_END);
		s.push_front(8'h82);
		s.push_front(8'h55);
		run_command(s, p);
		// second start byte throws away the partial frame
		p = make_payload(8'h82, 8'h02, 0, 32'h0);
		s = escaped_frame(p);
		s.push_front(8'hAA);
		s.push_front(8'h03);
		s.push_front(8'h02);
		s.push_front(BYTE_START);
		run_command(s, p);
		// missing data bytes stored as zero
		do_command(make_payload(8'h02, 8'h03, 2, 32'h0000_2211));
		do_command(make_payload(8'h82, 8'h03, 0, 32'h0));
		// seventh and eighth bytes dropped
		p = make_payload(8'h02, 8'h00, 4, 32'hCAFE_F00D);
		p.push_back(8'h99);
		p.push_back(8'h77);
		do_command(p);
		do_command(make_payload(8'h82, 8'h00, 0, 32'h0));

		if (error_count == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- uniboard_top.sv
// uniboard_top: serial command interface with peripheral bank
`timescale 1ns/1ns
`default_nettype none

module uniboard_top (
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic uart_tx
);
	logic [7:0] rx_byte;
	logic rx_valid;
	logic [7:0] tx_byte;
	logic send;
	logic busy;

	// decoder to sequencer
	frame_if frame_link ();
	// sequencer to peripherals
	reg_bus_if reg_bus ();

	uart_rx rx0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid)
	);

	frame_decoder dec0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.frame(frame_link.decoder)
	);

	protocol_sequencer seq0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.frame(frame_link.sequencer),
		.bus(reg_bus.master),
		.tx_byte(tx_byte),
		.send(send),
		.busy(busy)
	);

	peripheral_bank bank0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.bus(reg_bus.slave)
	);

	uart_tx tx0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.tx_byte(tx_byte),
		.send(send),
		.busy(busy),
		.uart_tx(uart_tx)
	);

endmodule

`default_nettype wire

//--- peripheral_bank.sv
// peripheral_bank: scratch register file, identity register, empty default
`timescale 1ns/1ns
`default_nettype none

module peripheral_bank (
	input logic clk_12MHz,
	input logic reset,
	reg_bus_if.slave bus
);
	import uniboard_pkg::*;

	logic select_d;
	logic [31:0] scratch [4];
	logic sel_rise;

	// writes land on the select rising edge
	assign sel_rise = bus.select & ~select_d;

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			select_d <= 1'b0;
			for (int i = 0; i < 4; i++)
				scratch[i] <= 32'h0;
		end
		else
		begin
			select_d <= bus.select;
			// low two address bits pick the entry
			if (sel_rise && !bus.rw && bus.periph_id == PERIPH_SCRATCH)
				scratch[bus.reg_addr[1:0]] <= bus.write_data;
		end
	end

	// registered, valid from the second select cycle
	always_ff @(posedge clk_12MHz)
	begin
		if (bus.select)
		begin
			case (bus.periph_id)
				PERIPH_SCRATCH:
				begin
					bus.read_data <= scratch[bus.reg_addr[1:0]];
					bus.reg_size <= 3'd4;
				end
				PERIPH_IDENT:
				begin
					// read only, writes have no target
					bus.read_data <= {16'h0000, UNIBOARD_ID};
					bus.reg_size <= 3'd2;
				end
				default:
				begin
					// empty register, header and address only
					bus.read_data <= 32'h0;
					bus.reg_size <= 3'd0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- protocol_sequencer.sv
// protocol_sequencer: register bus write and read-back, escaped reply transmission
`timescale 1ns/1ns
`default_nettype none

module protocol_sequencer (
	input logic clk_12MHz,
	input logic reset,
	frame_if.sequencer frame,
	reg_bus_if.master bus,
	output logic [7:0] tx_byte,
	output logic send,
	input logic busy
);
	import uniboard_pkg::*;

	logic [SEQ_STATE_W-1:0] state;
	logic [7:0] header_q;
	data_word_u rdata;
	logic [SIZE_W-1:0] size_q;
	// reply byte index, start byte is 0
	logic [2:0] idx;
	logic [7:0] pick_byte;
	logic pick_data;
	logic pick_esc;
	logic pick_last;
	logic [7:0] cur_q;
	logic last_q;

	// next reply byte from the index
	always_comb
	begin
		pick_byte = BYTE_END;
		pick_data = 1'b1;
		pick_last = 1'b0;
		if (idx == 3'd0)
		begin
			pick_byte = BYTE_START;
			pick_data = 1'b0;
		end
		else if (idx == 3'd1)
			pick_byte = header_q;
		else if (idx == 3'd2)
			pick_byte = bus.reg_addr;
		else if (idx < 3'd3 + size_q)
			pick_byte = rdata.bytes[2'(idx - 3'd3)];
		else
		begin
			pick_data = 1'b0;
			pick_last = 1'b1;
		end
		// framing bytes inside the reply get escaped
		pick_esc = pick_data & ((pick_byte == BYTE_START) | (pick_byte == BYTE_END)
			| (pick_byte == BYTE_ESC));
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state <= SEQ_IDLE;
			bus.select <= 1'b0;
			bus.rw <= 1'b0;
			send <= 1'b0;
			idx <= '0;
			last_q <= 1'b0;
		end
		else
		begin
			case (state)
				SEQ_IDLE:
					// frames arriving while busy are lost
					if (frame.frame_valid)
					begin
						bus.rw <= frame.header[READ_FLAG_BIT];
						state <= SEQ_SETUP;
					end
				SEQ_SETUP:
				begin
					// bus settled for one cycle
					bus.select <= 1'b1;
					state <= SEQ_SEL1;
				end
				SEQ_SEL1:
					state <= SEQ_SEL2;
				SEQ_SEL2:
				begin
					bus.select <= 1'b0;
					idx <= '0;
					state <= bus.rw ? SEQ_PICK : SEQ_GAP;
				end
				SEQ_GAP:
				begin
					// then read back the same register
					bus.rw <= 1'b1;
					state <= SEQ_SETUP;
				end
				SEQ_PICK:
				begin
					last_q <= pick_last;
					state <= pick_esc ? SEQ_ESC : SEQ_BYTE;
				end
				SEQ_ESC:
					if (!busy)
					begin
						send <= 1'b1;
						state <= SEQ_ESC_HOLD;
					end
				SEQ_ESC_HOLD:
				begin
					send <= 1'b0;
					state <= SEQ_BYTE;
				end
				SEQ_BYTE:
					if (!busy)
					begin
						send <= 1'b1;
						state <= SEQ_HOLD;
					end
				default:
				begin
					// busy is up from the next cycle
					send <= 1'b0;
					idx <= idx + 1'b1;
					state <= last_q ? SEQ_IDLE : SEQ_PICK;
				end
			endcase
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == SEQ_IDLE && frame.frame_valid)
		begin
			header_q <= frame.header;
			bus.periph_id <= frame.header[PERIPH_ID_W-1:0];
			bus.reg_addr <= frame.reg_addr;
			bus.write_data <= frame.data.word;
		end
		// second select cycle, read data valid
		if (state == SEQ_SEL2 && bus.rw)
		begin
			rdata.word <= bus.read_data;
			// no more than four data bytes in a reply
			size_q <= (bus.reg_size > 3'd4) ? 3'd4 : bus.reg_size;
		end
		if (state == SEQ_PICK)
			cur_q <= pick_byte;
		if ((state == SEQ_ESC || state == SEQ_BYTE) && !busy)
			tx_byte <= (state == SEQ_ESC) ? BYTE_ESC : cur_q;
	end

endmodule

`default_nettype wire

//--- frame_decoder.sv
// frame_decoder: escape removal, payload buffer and frame announcement
`timescale 1ns/1ns
`default_nettype none

module frame_decoder (
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] rx_byte,
	input logic rx_valid,
	frame_if.decoder frame
);
	import uniboard_pkg::*;

	logic in_frame;
	logic escape;
	logic [BUF_CNT_W-1:0] count;
	logic [7:0] buffer [PAYLOAD_BYTES];
	logic special;
	logic do_open;
	logic do_close;
	logic do_escape;
	logic do_deposit;
	logic frame_ok;

	assign special = (rx_byte == BYTE_START) | (rx_byte == BYTE_END) | (rx_byte == BYTE_ESC);

	// escaped start is data, anything else with start reopens
	assign do_open = rx_valid & (rx_byte == BYTE_START) & (~in_frame | ~escape);
	assign do_close = rx_valid & in_frame & ~escape & (rx_byte == BYTE_END);
	assign do_escape = rx_valid & in_frame & ~escape & (rx_byte == BYTE_ESC);
	// extra bytes past the sixth fall on the floor
	assign do_deposit = rx_valid & in_frame & (escape | ~special)
		& (count < BUF_CNT_W'(PAYLOAD_BYTES));
	// need header and address at least
	assign frame_ok = do_close & (count >= BUF_CNT_W'(2));

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			in_frame <= 1'b0;
			escape <= 1'b0;
			count <= '0;
			frame.frame_valid <= 1'b0;
		end
		else
		begin
			frame.frame_valid <= frame_ok;
			if (do_open)
			begin
				in_frame <= 1'b1;
				escape <= 1'b0;
				count <= '0;
			end
			else if (do_close)
				in_frame <= 1'b0;
			else if (do_escape)
				escape <= 1'b1;
			else if (rx_valid && in_frame)
			begin
				escape <= 1'b0;
				if (do_deposit)
					count <= count + 1'b1;
			end
		end
	end

	// zero fill so short writes store zeros
	always_ff @(posedge clk_12MHz)
	begin
		if (do_open)
		begin
			for (int i = 0; i < PAYLOAD_BYTES; i++)
				buffer[i] <= 8'h00;
		end
		else if (do_deposit)
			buffer[count] <= rx_byte;
	end

	// hold fields stable until the next frame
	always_ff @(posedge clk_12MHz)
	begin
		if (frame_ok)
		begin
			frame.header <= buffer[0];
			frame.reg_addr <= buffer[1];
			for (int i = 0; i < 4; i++)
				frame.data.bytes[i] <= buffer[i + 2];
		end
	end

endmodule

`default_nettype wire

//--- uart_tx.sv
// uart_tx: 8N1 serial transmitter with send strobe and busy level
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
	input logic clk_12MHz,
	input logic reset,
	input logic [7:0] tx_byte,
	input logic send,
	output logic busy,
	output logic uart_tx
);
	logic start;
	logic bit_tick;
	logic [8:0] shreg;
	logic [3:0] bit_cnt;

	// strobe ignored while a byte is going out
	assign start = send & ~busy;

	baud_timer timer0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.restart(start),
		.mid_tick(),
		.bit_tick(bit_tick)
	);

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			uart_tx <= 1'b1;
			busy <= 1'b0;
			bit_cnt <= '0;
		end
		else if (start)
		begin
			// start bit goes out right away
			uart_tx <= 1'b0;
			busy <= 1'b1;
			bit_cnt <= '0;
		end
		else if (busy && bit_tick)
		begin
			// tenth tick ends the stop bit
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
			else
				uart_tx <= shreg[0];
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// data bits then stop bit, ones shifted in behind
	always_ff @(posedge clk_12MHz)
	begin
		if (start)
			shreg <= {1'b1, tx_byte};
		else if (busy && bit_tick)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

//--- uart_rx.sv
// uart_rx: 8N1 serial receiver with one-cycle byte valid pulse
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
	input logic clk_12MHz,
	input logic reset,
	input logic uart_rx,
	output logic [7:0] rx_byte,
	output logic rx_valid
);
	import uniboard_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic restart;
	logic mid_tick;
	logic [RX_STATE_W-1:0] state;
	logic [2:0] bit_cnt;

	// falling edge on the synchronized line
	assign start_edge = rx_prev & ~rx_sync;
	assign restart = (state == RX_IDLE) & start_edge;

	// only mid-bit sampling needed here
	baud_timer timer0 (
		.clk_12MHz(clk_12MHz),
		.reset(reset),
		.restart(restart),
		.mid_tick(mid_tick),
		.bit_tick()
	);

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state <= RX_IDLE;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			// two-flop sync, line idles high
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE:
					if (start_edge)
						state <= RX_START;
				RX_START:
					if (mid_tick)
					begin
						// high again at mid-start is a glitch
						state <= rx_sync ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
				RX_DATA:
					if (mid_tick)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				default:
					if (mid_tick)
					begin
						// bad stop bit drops the byte
						rx_valid <= rx_sync;
						state <= RX_IDLE;
					end
			endcase
		end
	end

	// lsb first into the top
	always_ff @(posedge clk_12MHz)
	begin
		if (state == RX_DATA && mid_tick)
			rx_byte <= {rx_sync, rx_byte[7:1]};
	end

endmodule

`default_nettype wire

//--- baud_timer.sv
// baud_timer: bit period counter with mid-bit and end-of-bit ticks
`timescale 1ns/1ns
`default_nettype none

module baud_timer (
	input logic clk_12MHz,
	input logic reset,
	input logic restart,
	output logic mid_tick,
	output logic bit_tick
);
	import uniboard_pkg::*;

	logic [BAUD_CNT_W-1:0] cnt;

	// counts 0 .. BAUD_DIV-1, back to 0 on restart
	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
			cnt <= '0;
		else if (restart || cnt == BAUD_CNT_W'(BAUD_DIV - 1))
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// half period after restart, then once per period
	assign mid_tick = (cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1));
	// full period after restart
	assign bit_tick = (cnt == BAUD_CNT_W'(BAUD_DIV - 1));

endmodule

`default_nettype wire

//--- uniboard_if.sv
// frame_if and reg_bus_if interfaces with their modports
`timescale 1ns/1ns
`default_nettype none

interface frame_if;
	import uniboard_pkg::*;

	// one-cycle pulse, fields held until the next one
	logic frame_valid;
	logic [7:0] header;
	logic [7:0] reg_addr;
	data_word_u data;

	modport decoder (
		output frame_valid,
		output header,
		output reg_addr,
		output data
	);

	modport sequencer (
		input frame_valid,
		input header,
		input reg_addr,
		input data
	);
endinterface

interface reg_bus_if;
	import uniboard_pkg::*;

	logic [PERIPH_ID_W-1:0] periph_id;
	logic [7:0] reg_addr;
	// high means read
	logic rw;
	logic [31:0] write_data;
	logic select;
	logic [31:0] read_data;
	logic [SIZE_W-1:0] reg_size;

	modport master (
		output periph_id,
		output reg_addr,
		output rw,
		output write_data,
		output select,
		input read_data,
		input reg_size
	);

	modport slave (
		input periph_id,
		input reg_addr,
		input rw,
		input write_data,
		input select,
		output read_data,
		output reg_size
	);
endinterface

`default_nettype wire

//--- uniboard_pkg.sv
// uniboard_pkg: framing bytes, widths, baud divisor, peripheral ids, fsm codes, data word union
`default_nettype none

package uniboard_pkg;

	// frame delimiters and escape
	localparam logic [7:0] BYTE_START = 8'h01;
	localparam logic [7:0] BYTE_END = 8'h17;
	localparam logic [7:0] BYTE_ESC = 8'h1B;

	// header, address, four data bytes
	localparam int PAYLOAD_BYTES = 6;
	localparam int BUF_CNT_W = $clog2(PAYLOAD_BYTES + 1);

	// 12 MHz / 12 = 1 Mbaud
	localparam int BAUD_DIV = 12;
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	localparam int PERIPH_ID_W = 7;
	localparam int READ_FLAG_BIT = 7;
	localparam int SIZE_W = 3;

	localparam logic [PERIPH_ID_W-1:0] PERIPH_SCRATCH = 7'd2;
	localparam logic [PERIPH_ID_W-1:0] PERIPH_IDENT = 7'd7;
	localparam logic [15:0] UNIBOARD_ID = 16'h5542;

	// receiver states
	localparam int RX_STATE_W = 2;
	localparam logic [RX_STATE_W-1:0] RX_IDLE = 2'd0;
	localparam logic [RX_STATE_W-1:0] RX_START = 2'd1;
	localparam logic [RX_STATE_W-1:0] RX_DATA = 2'd2;
	localparam logic [RX_STATE_W-1:0] RX_STOP = 2'd3;

	// sequencer states
	localparam int SEQ_STATE_W = 4;
	localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE = 4'd0;
	localparam logic [SEQ_STATE_W-1:0] SEQ_SETUP = 4'd1;
	localparam logic [SEQ_STATE_W-1:0] SEQ_SEL1 = 4'd2;
	localparam logic [SEQ_STATE_W-1:0] SEQ_SEL2 = 4'd3;
	localparam logic [SEQ_STATE_W-1:0] SEQ_GAP = 4'd4;
	localparam logic [SEQ_STATE_W-1:0] SEQ_PICK = 4'd5;
	localparam logic [SEQ_STATE_W-1:0] SEQ_ESC = 4'd6;
	localparam logic [SEQ_STATE_W-1:0] SEQ_ESC_HOLD = 4'd7;
	localparam logic [SEQ_STATE_W-1:0] SEQ_BYTE = 4'd8;
	localparam logic [SEQ_STATE_W-1:0] SEQ_HOLD = 4'd9;

	// register word: whole word on the bus, bytes on the serial side
	typedef union packed {
		logic [31:0] word;
		logic [3:0][7:0] bytes;
	} data_word_u;

endpackage

`default_nettype wire
